// File: conv_tiled_cfg.svh
/*
 * sizes and widths of the tiled convolution engine
 * tile shape, data widths, buffer and FIFO depths
 */
`ifndef CONV_TILED_CFG_SVH
`define CONV_TILED_CFG_SVH

`define CONV_IC0              4     // input channels per ifmap beat
`define CONV_OC0              4     // output lanes per weight beat
`define CONV_DAT_W            16    // ifmap and weight samples
`define CONV_ACC_W            32    // accumulator and ofmap word
`define CONV_PARAM_W          16    // one field of the parameter word
`define CONV_ADDR_W           10    // buffer address

// on-chip buffers, must hold a whole tile
`define CONV_IFMAP_DEPTH      1024
`define CONV_WEIGHT_DEPTH     1024
`define CONV_OFMAP_FIFO_DEPTH 4     // finished pixel vectors

`endif

// File: conv_pkg.sv
/*
 * shared types of the convolution engine
 * layer parameter word, lane vectors, phase FSM states
 */
`include "conv_tiled_cfg.svh"

package conv_pkg;

  // host parameter beat, oc1 in the top bits
  typedef struct packed {
    logic [`CONV_PARAM_W-1:0] oc1;
    logic [`CONV_PARAM_W-1:0] ic1;
    logic [`CONV_PARAM_W-1:0] fy;     // square kernel, fx == fy
    logic [`CONV_PARAM_W-1:0] oy0;    // square output tile
    logic [`CONV_PARAM_W-1:0] stride;
  } layer_params_t;

  // lanes are signed, cast with $signed where multiplied
  typedef logic [`CONV_IC0-1:0][`CONV_DAT_W-1:0] ifmap_vec_t;
  typedef logic [`CONV_OC0-1:0][`CONV_DAT_W-1:0] weight_vec_t;
  typedef logic [`CONV_OC0-1:0][`CONV_ACC_W-1:0] acc_vec_t;   // one output pixel

  // layer phases, loading and computing never overlap
  typedef enum logic [1:0] {
    IDLE,   // waiting for a parameter beat
    LOAD,   // filling both buffers
    RUN,    // sequencer active
    DRAIN   // last pixels leaving
  } phase_t;

endpackage

// File: stream_buffer.sv
/*
 * valid/ready stream ingest into a single-port RAM
 * in-order write from address 0, registered read port
 */
`timescale 1ns/1ps
`include "conv_tiled_cfg.svh"

module stream_buffer #(
  parameter type word_t = logic [63:0],
  parameter int  DEPTH  = 1024
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load_en,
  input  logic [`CONV_ADDR_W-1:0] load_len,   // beats expected this layer
  input  word_t                   in_dat,
  input  logic                    in_vld,
  output logic                    in_rdy,
  output logic                    full,
  input  logic                    ren,
  input  logic [`CONV_ADDR_W-1:0] raddr,
  output word_t                   rdata
);

  word_t                   mem [DEPTH];
  logic [`CONV_ADDR_W-1:0] count;   // beats written, also the write address
  logic                    wr;

  assign in_rdy = load_en && (count < load_len);
  assign full   = load_en && (count == load_len);
  assign wr     = in_vld && in_rdy;

  // beat counter, cleared whenever the load window closes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (!load_en) begin
      count <= '0;
    end else if (wr) begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[count] <= in_dat;
    end
    if (ren) begin
      rdata <= mem[raddr];   // 1 cycle read latency
    end
  end

endmodule

// File: loop_sequencer.sv
/*
 * loop nest of one layer: oc1 / oy / ox / ic1 / ky / kx / ic0
 * buffer read addresses, first/last tags, ifmap lane select
 */
`timescale 1ns/1ps
`include "conv_tiled_cfg.svh"

module loop_sequencer import conv_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic [`CONV_PARAM_W-1:0] oc1_max,
  input  logic [`CONV_PARAM_W-1:0] oy0_max,
  input  logic [`CONV_PARAM_W-1:0] iy0,
  input  logic [`CONV_PARAM_W-1:0] stride,
  input  logic [`CONV_PARAM_W-1:0] fy,
  input  logic [`CONV_PARAM_W-1:0] ic1,
  input  logic                     has_room,
  input  ifmap_vec_t               ifmap_rdata,
  output logic                     ifmap_ren,
  output logic [`CONV_ADDR_W-1:0]  ifmap_raddr,
  output logic                     weight_ren,
  output logic [`CONV_ADDR_W-1:0]  weight_raddr,
  output logic [`CONV_DAT_W-1:0]   lane_dat,
  output logic                     acc_first,
  output logic                     acc_last,
  output logic                     done
);

  localparam int SEL_W = $clog2(`CONV_IC0);

  logic                     busy;
  logic                     step;     // one MAC row issued this cycle
  logic                     rd_vld;   // read data valid, step delayed
  logic [SEL_W-1:0]         ic0;
  logic [SEL_W-1:0]         sel;
  logic [`CONV_PARAM_W-1:0] kx, ky, c1, ox, oy, oc1;
  logic [`CONV_ADDR_W-1:0]  w_base;   // first weight of the current oc1 block
  logic [`CONV_ADDR_W-1:0]  w_idx;
  logic [31:0]              row, col, ifa;
  logic                     kx_wrap, ky_wrap, c1_wrap, pix_end, ox_wrap, blk_end;
  logic                     pix_first;

  assign step       = busy && has_room;   // stall whole nest on a full FIFO
  assign ifmap_ren  = step;
  assign weight_ren = step;

  // wrap conditions, each level includes all inner ones
  assign kx_wrap   = (ic0 == SEL_W'(`CONV_IC0 - 1)) && (kx == fy - 1'b1);
  assign ky_wrap   = kx_wrap && (ky == fy - 1'b1);
  assign c1_wrap   = ky_wrap && (c1 == ic1 - 1'b1);
  assign pix_end   = c1_wrap;             // last row of one output pixel
  assign ox_wrap   = pix_end && (ox == oy0_max);
  assign blk_end   = ox_wrap && (oy == oy0_max);   // oc1 block finished
  assign pix_first = (ic0 == '0) && (kx == '0) && (ky == '0) && (c1 == '0);

  // ifmap beat index: ic1 plane, then row, then column
  assign row         = oy * stride + ky;
  assign col         = ox * stride + kx;
  assign ifa         = (c1 * iy0 + row) * iy0 + col;
  assign ifmap_raddr = ifa[`CONV_ADDR_W-1:0];
  assign weight_raddr = w_idx;

  // idle cycles feed a zero sample so the MAC sums stay put
  assign lane_dat = rd_vld ? ifmap_rdata[sel] : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      ic0    <= '0;
      kx     <= '0;
      ky     <= '0;
      c1     <= '0;
      ox     <= '0;
      oy     <= '0;
      oc1    <= '0;
      w_base <= '0;
      w_idx  <= '0;
    end else if (start) begin
      busy   <= 1'b1;
      done   <= 1'b0;
      ic0    <= '0;
      kx     <= '0;
      ky     <= '0;
      c1     <= '0;
      ox     <= '0;
      oy     <= '0;
      oc1    <= '0;
      w_base <= '0;
      w_idx  <= '0;
    end else if (step) begin
      ic0 <= (ic0 == SEL_W'(`CONV_IC0 - 1)) ? '0 : ic0 + 1'b1;
      if (ic0 == SEL_W'(`CONV_IC0 - 1)) kx <= (kx == fy - 1'b1) ? '0 : kx + 1'b1;
      if (kx_wrap) ky <= (ky == fy - 1'b1) ? '0 : ky + 1'b1;
      if (ky_wrap) c1 <= (c1 == ic1 - 1'b1) ? '0 : c1 + 1'b1;
      if (pix_end) ox <= (ox == oy0_max) ? '0 : ox + 1'b1;
      if (ox_wrap) oy <= (oy == oy0_max) ? '0 : oy + 1'b1;
      if (blk_end) oc1 <= oc1 + 1'b1;
      // weights replay per pixel, advance only past a whole block
      if (pix_end && !blk_end) begin
        w_idx <= w_base;
      end else begin
        w_idx <= w_idx + 1'b1;
      end
      if (blk_end) w_base <= w_idx + 1'b1;
      if (blk_end && (oc1 == oc1_max)) begin
        busy <= 1'b0;
        done <= 1'b1;   // held until the next start
      end
    end
  end

  // tags travel one cycle to meet the RAM read data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_vld    <= 1'b0;
      acc_first <= 1'b0;
      acc_last  <= 1'b0;
    end else begin
      rd_vld    <= step;
      acc_first <= step && pix_first;
      acc_last  <= step && pix_end;
    end
  end

  always_ff @(posedge clk) begin
    if (step) sel <= ic0;   // lane of the ifmap beat being read
  end

endmodule

// File: mac_row.sv
/*
 * row of OC0 signed multiply-accumulate lanes
 * first tag restarts the sums, last tag emits a pixel
 */
`timescale 1ns/1ps
`include "conv_tiled_cfg.svh"

module mac_row import conv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`CONV_DAT_W-1:0] lane_dat,     // one ifmap channel, broadcast
  input  weight_vec_t            weight_dat,
  input  logic                   acc_first,
  input  logic                   acc_last,
  output logic                   pix_vld,
  output acc_vec_t               pix_dat
);

  logic signed [`CONV_ACC_W-1:0] prod [`CONV_OC0];
  acc_vec_t                      acc;
  acc_vec_t                      sum;

  always_comb begin
    for (int o = 0; o < `CONV_OC0; o++) begin
      // 16x16 signed fits in 32, sign extended by the signed context
      prod[o] = $signed(lane_dat) * $signed(weight_dat[o]);
      sum[o]  = (acc_first ? '0 : acc[o]) + prod[o];   // wraps mod 2^32
    end
  end

  always_ff @(posedge clk) begin
    acc <= sum;   // zero sample on idle cycles keeps the sums
    if (acc_last) begin
      pix_dat <= sum;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_vld <= 1'b0;
    end else begin
      pix_vld <= acc_last;   // 2 cycles after the final read
    end
  end

endmodule

// File: ofmap_serializer.sv
/*
 * FIFO of finished pixel vectors
 * head pixel sent as 32-bit words, lane 0 first
 */
`timescale 1ns/1ps
`include "conv_tiled_cfg.svh"

module ofmap_serializer import conv_pkg::*; #(
  parameter int FIFO_DEPTH = `CONV_OFMAP_FIFO_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pix_vld,
  input  acc_vec_t               pix_dat,
  output logic [`CONV_ACC_W-1:0] ofmap_dat,
  output logic                   ofmap_vld,
  input  logic                   ofmap_rdy,
  output logic                   has_room,
  output logic                   idle
);

  localparam int PTR_W  = $clog2(FIFO_DEPTH);
  localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
  localparam int LANE_W = $clog2(`CONV_OC0);

  acc_vec_t          fifo [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr, rd_ptr;
  logic [CNT_W-1:0]  count;   // pixels stored
  logic [LANE_W-1:0] lane;    // next word of the head pixel
  logic              push, pop, lane_end;

  assign push      = pix_vld;   // has_room keeps a free slot for it
  assign lane_end  = (lane == LANE_W'(`CONV_OC0 - 1));
  assign pop       = ofmap_vld && ofmap_rdy && lane_end;
  assign ofmap_vld = (count != '0);
  assign ofmap_dat = fifo[rd_ptr][lane];   // stable until accepted

  // two slots free covers the pixel still in the MAC pipe
  assign has_room  = (count <= CNT_W'(FIFO_DEPTH - 2));
  assign idle      = (count == '0) && !pix_vld;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      lane   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (ofmap_vld && ofmap_rdy) begin
        lane <= lane_end ? '0 : lane + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) fifo[wr_ptr] <= pix_dat;
  end

endmodule

// File: layer_ctrl.sv
/*
 * layer parameter register and derived sizes
 * IDLE / LOAD / RUN / DRAIN phase FSM
 */
`timescale 1ns/1ps
`include "conv_tiled_cfg.svh"

module layer_ctrl import conv_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  layer_params_t            params,
  input  logic                     params_vld,
  output logic                     params_rdy,
  input  logic                     ifmap_full,
  input  logic                     weight_full,
  input  logic                     seq_done,
  input  logic                     out_idle,
  output logic                     load_en,
  output logic [`CONV_ADDR_W-1:0]  ifmap_len,
  output logic [`CONV_ADDR_W-1:0]  weight_len,
  output logic                     start,
  output logic [`CONV_PARAM_W-1:0] oc1_max,
  output logic [`CONV_PARAM_W-1:0] oy0_max,
  output logic [`CONV_PARAM_W-1:0] iy0,
  output logic [`CONV_PARAM_W-1:0] stride,
  output logic [`CONV_PARAM_W-1:0] fy,
  output logic [`CONV_PARAM_W-1:0] ic1
);

  phase_t        state;
  layer_params_t cfg;
  logic [31:0]   ifmap_cnt, weight_cnt;

  assign params_rdy = (state == IDLE);
  assign load_en    = (state == LOAD);

  // input tile edge from output tile, kernel and stride
  assign iy0        = cfg.stride * (cfg.oy0 - 1'b1) + cfg.fy;
  assign ifmap_cnt  = cfg.ic1 * iy0 * iy0;
  assign weight_cnt = cfg.oc1 * cfg.ic1 * cfg.fy * cfg.fy * `CONV_IC0;
  assign ifmap_len  = ifmap_cnt[`CONV_ADDR_W-1:0];
  assign weight_len = weight_cnt[`CONV_ADDR_W-1:0];

  // loop limits
  assign oc1_max = cfg.oc1 - 1'b1;
  assign oy0_max = cfg.oy0 - 1'b1;
  assign stride  = cfg.stride;
  assign fy      = cfg.fy;
  assign ic1     = cfg.ic1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      cfg   <= '0;
      start <= 1'b0;
    end else begin
      start <= 1'b0;
      case (state)
        IDLE: begin
          if (params_vld) begin
            cfg   <= params;
            state <= LOAD;
          end
        end
        LOAD: begin
          if (ifmap_full && weight_full) begin
            state <= RUN;
            start <= 1'b1;   // high in the first RUN cycle
          end
        end
        // done of the previous layer still up while start is high
        RUN: if (seq_done && !start) state <= DRAIN;
        DRAIN: if (seq_done && out_idle) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: conv_tiled.sv
/*
 * top level of the one-layer convolution engine
 * phase control, two input buffers, sequencer, MAC row, ofmap serializer
 */
`timescale 1ns/1ps
`include "conv_tiled_cfg.svh"

module conv_tiled import conv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  ifmap_vec_t             ifmap_dat,
  input  logic                   ifmap_vld,
  output logic                   ifmap_rdy,
  input  weight_vec_t            weights_dat,
  input  logic                   weights_vld,
  output logic                   weights_rdy,
  output logic [`CONV_ACC_W-1:0] ofmap_dat,
  output logic                   ofmap_vld,
  input  logic                   ofmap_rdy,
  input  layer_params_t          layer_params_dat,
  input  logic                   layer_params_vld,
  output logic                   layer_params_rdy
);

  logic                     load_en, start, seq_done, out_idle, has_room;
  logic                     ifmap_full, weight_full;
  logic [`CONV_ADDR_W-1:0]  ifmap_len, weight_len;
  logic [`CONV_PARAM_W-1:0] oc1_max, oy0_max, iy0, stride, fy, ic1;
  logic                     ifmap_ren, weight_ren;
  logic [`CONV_ADDR_W-1:0]  ifmap_raddr, weight_raddr;
  ifmap_vec_t               ifmap_rdata;
  weight_vec_t              weight_rdata;
  logic [`CONV_DAT_W-1:0]   lane_dat;
  logic                     acc_first, acc_last, pix_vld;
  acc_vec_t                 pix_dat;

  layer_ctrl i_layer_ctrl (
    .clk, .rst_n,
    .params(layer_params_dat), .params_vld(layer_params_vld), .params_rdy(layer_params_rdy),
    .ifmap_full, .weight_full, .seq_done, .out_idle,
    .load_en, .ifmap_len, .weight_len, .start,
    .oc1_max, .oy0_max, .iy0, .stride, .fy, .ic1
  );

  stream_buffer #(.word_t(ifmap_vec_t), .DEPTH(`CONV_IFMAP_DEPTH)) i_ifmap_buf (
    .clk, .rst_n, .load_en, .load_len(ifmap_len),
    .in_dat(ifmap_dat), .in_vld(ifmap_vld), .in_rdy(ifmap_rdy), .full(ifmap_full),
    .ren(ifmap_ren), .raddr(ifmap_raddr), .rdata(ifmap_rdata)
  );

  stream_buffer #(.word_t(weight_vec_t), .DEPTH(`CONV_WEIGHT_DEPTH)) i_weight_buf (
    .clk, .rst_n, .load_en, .load_len(weight_len),
    .in_dat(weights_dat), .in_vld(weights_vld), .in_rdy(weights_rdy), .full(weight_full),
    .ren(weight_ren), .raddr(weight_raddr), .rdata(weight_rdata)
  );

  loop_sequencer i_loop_sequencer (
    .clk, .rst_n, .start,
    .oc1_max, .oy0_max, .iy0, .stride, .fy, .ic1,
    .has_room, .ifmap_rdata,
    .ifmap_ren, .ifmap_raddr, .weight_ren, .weight_raddr,
    .lane_dat, .acc_first, .acc_last, .done(seq_done)
  );

  mac_row i_mac_row (
    .clk, .rst_n, .lane_dat, .weight_dat(weight_rdata),
    .acc_first, .acc_last, .pix_vld, .pix_dat
  );

  ofmap_serializer #(.FIFO_DEPTH(`CONV_OFMAP_FIFO_DEPTH)) i_ofmap_serializer (
    .clk, .rst_n, .pix_vld, .pix_dat,
    .ofmap_dat, .ofmap_vld, .ofmap_rdy,
    .has_room, .idle(out_idle)
  );

endmodule

// File: conv_tiled_chk.sv
/*
 * concurrent assertions on the convolution engine ports
 * ofmap hold under back-pressure, exclusive ready signals, reset state
 */
`timescale 1ns/1ps
`include "conv_tiled_cfg.svh"

module conv_tiled_chk import conv_pkg::*; (
  input logic                   clk,
  input logic                   rst_n,
  input logic [`CONV_ACC_W-1:0] ofmap_dat,
  input logic                   ofmap_vld,
  input logic                   ofmap_rdy,
  input logic                   layer_params_rdy,
  input logic                   ifmap_rdy,
  input phase_t                 phase        // layer_ctrl state
);

  int unsigned n_fail = 0;   // read by the testbench summary

  // a stalled ofmap beat keeps its word until taken
  ofmap_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ofmap_vld && !ofmap_rdy |=> ofmap_vld && $stable(ofmap_dat))
    else begin
      $error("ofmap word changed or dropped before it was accepted");
      n_fail++;
    end

  rdy_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(layer_params_rdy && ifmap_rdy))
    else begin
      $error("parameter and ifmap streams ready in the same cycle");
      n_fail++;
    end

  // no disable here, the reset cycle itself is checked
  vld_after_rst: assert property (@(posedge clk) !rst_n |=> !ofmap_vld)
    else begin
      $error("ofmap valid high right after reset");
      n_fail++;
    end

  vld_phase: assert property (@(posedge clk) disable iff (!rst_n)
    ofmap_vld |-> (phase == RUN || phase == DRAIN))
    else begin
      $error("ofmap valid outside the RUN and DRAIN phases");
      n_fail++;
    end

endmodule

bind conv_tiled conv_tiled_chk i_chk (
  .clk, .rst_n, .ofmap_dat, .ofmap_vld, .ofmap_rdy,
  .layer_params_rdy, .ifmap_rdy, .phase(i_layer_ctrl.state)
);

// File: conv_tiled_mon.sv
/*
 * ofmap stream monitor
 * queue of expected words, in-order compare of every accepted beat
 */
`timescale 1ns/1ps
`include "conv_tiled_cfg.svh"

module conv_tiled_mon import conv_pkg::*; (
  input logic                   clk,
  input logic                   rst_n,
  input logic [`CONV_ACC_W-1:0] ofmap_dat,
  input logic                   ofmap_vld,
  input logic                   ofmap_rdy
);

  logic [`CONV_ACC_W-1:0] exp_q [$];   // filled by the reference model
  logic [`CONV_ACC_W-1:0] exp_w;
  int unsigned            n_words = 0;   // accepted ofmap beats
  int unsigned            n_err   = 0;   // wrong values
  int unsigned            n_extra = 0;   // beats with nothing expected

  function automatic void expect_word(input logic [`CONV_ACC_W-1:0] w);
    exp_q.push_back(w);
  endfunction

  // beat transfers on this edge when both were high before it
  always @(posedge clk) begin
    if (rst_n && ofmap_vld && ofmap_rdy) begin
      if (exp_q.size() == 0) begin
        $display("unexpected ofmap word %h at %0t, no word was left to expect",
                 ofmap_dat, $time);
        n_extra++;
      end else begin
        exp_w = exp_q.pop_front();
        if (ofmap_dat !== exp_w) begin
          $display("ERR %0t: ofmap word %0d is %h, expected %h",
                   $time, n_words, ofmap_dat, exp_w);
          n_err++;
        end
      end
      n_words++;
    end
  end

endmodule

// File: tb_conv_tiled.sv
/*
 * testbench of the convolution engine
 * clock, reset, LCG stimulus, reference model, layer runs, timeout, summary
 */
`timescale 1ns/1ps
`include "conv_tiled_cfg.svh"

module tb_conv_tiled import conv_pkg::*; ();

  logic                   clk;
  logic                   rst_n;
  ifmap_vec_t             ifmap_dat;
  logic                   ifmap_vld, ifmap_rdy;
  weight_vec_t            weights_dat;
  logic                   weights_vld, weights_rdy;
  logic [`CONV_ACC_W-1:0] ofmap_dat;
  logic                   ofmap_vld, ofmap_rdy;
  layer_params_t          layer_params_dat;
  logic                   layer_params_vld, layer_params_rdy;

  ifmap_vec_t    ifm [`CONV_IFMAP_DEPTH];    // tile as sent
  weight_vec_t   wts [`CONV_WEIGHT_DEPTH];
  logic [31:0]   rng_dat, rng_in, rng_wt, rng_out;   // one LCG state per use
  logic          rdy_random;   // ofmap back-pressure on
  int unsigned   tb_errs = 0;
  int unsigned   limit   = 0;  // timeout in cycles
  int unsigned   cycles  = 0;
  layer_params_t t_min, t_big, t_b2b;

  conv_tiled i_dut (.*);
  conv_tiled_mon i_mon (.clk, .rst_n, .ofmap_dat, .ofmap_vld, .ofmap_rdy);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg(inout logic [31:0] s);
    s = s * 32'd1103515245 + 32'd12345;
    return {16'h0, s[31:16]};   // upper bits since the low ones cycle short
  endfunction

  function automatic layer_params_t make_params(input int oc1, ic1, fy, oy0, stride);
    layer_params_t p;
    p.oc1    = 16'(oc1);
    p.ic1    = 16'(ic1);
    p.fy     = 16'(fy);
    p.oy0    = 16'(oy0);
    p.stride = 16'(stride);
    return p;
  endfunction

  function automatic int ifmap_beats(input layer_params_t p);
    int iy;
    iy = p.stride * (p.oy0 - 1) + p.fy;
    return p.ic1 * iy * iy;
  endfunction

  function automatic int weight_beats(input layer_params_t p);
    return p.oc1 * p.ic1 * p.fy * p.fy * `CONV_IC0;
  endfunction

  // params beat + loads + MAC rows + output words
  function automatic int layer_cycles(input layer_params_t p);
    return 1 + ifmap_beats(p) + weight_beats(p)
           + p.oc1 * p.oy0 * p.oy0 * p.ic1 * p.fy * p.fy * `CONV_IC0
           + p.oc1 * p.oy0 * p.oy0 * `CONV_OC0;
  endfunction

  function automatic void fill_data();
    for (int i = 0; i < `CONV_IFMAP_DEPTH; i++) begin
      for (int c = 0; c < `CONV_IC0; c++) ifm[i][c] = 16'(lcg(rng_dat));
    end
    for (int i = 0; i < `CONV_WEIGHT_DEPTH; i++) begin
      for (int l = 0; l < `CONV_OC0; l++) wts[i][l] = 16'(lcg(rng_dat));
    end
  endfunction

  // expected ofmap words in stream order oc1 / oy / ox / lane
  function automatic int conv_ref(input layer_params_t p);
    int iy, n, a, w, acc, ia, wa;
    iy = p.stride * (p.oy0 - 1) + p.fy;
    n  = 0;
    for (int o1 = 0; o1 < p.oc1; o1++)
      for (int oy = 0; oy < p.oy0; oy++)
        for (int ox = 0; ox < p.oy0; ox++)
          for (int l = 0; l < `CONV_OC0; l++) begin
            acc = 0;
            for (int c1 = 0; c1 < p.ic1; c1++)
              for (int ky = 0; ky < p.fy; ky++)
                for (int kx = 0; kx < p.fy; kx++)
                  for (int c0 = 0; c0 < `CONV_IC0; c0++) begin
                    ia  = (c1 * iy + oy * p.stride + ky) * iy + ox * p.stride + kx;
                    wa  = (((o1 * p.ic1 + c1) * p.fy + ky) * p.fy + kx) * `CONV_IC0 + c0;
                    a   = $signed(ifm[ia][c0]);
                    w   = $signed(wts[wa][l]);
                    acc = acc + a * w;   // int wraps mod 2^32
                  end
            i_mon.expect_word(acc);
            n++;
          end
    return n;
  endfunction

  task automatic send_params(input layer_params_t p);
    layer_params_dat = p;
    layer_params_vld = 1'b1;
    @(posedge clk);
    while (!layer_params_rdy) @(posedge clk);
    @(negedge clk);
    layer_params_vld = 1'b0;
  endtask

  task automatic send_ifmap(input int n, input bit gaps);
    int gap;
    for (int i = 0; i < n; i++) begin
      gap = gaps ? int'(lcg(rng_in) % 3) : 0;
      ifmap_vld = 1'b0;
      repeat (gap) @(negedge clk);
      ifmap_dat = ifm[i];
      ifmap_vld = 1'b1;
      @(posedge clk);
      while (!ifmap_rdy) @(posedge clk);
      @(negedge clk);
    end
    ifmap_vld = 1'b0;
  endtask

  task automatic send_weights(input int n, input bit gaps);
    int gap;
    for (int i = 0; i < n; i++) begin
      gap = gaps ? int'(lcg(rng_wt) % 3) : 0;
      weights_vld = 1'b0;
      repeat (gap) @(negedge clk);
      weights_dat = wts[i];
      weights_vld = 1'b1;
      @(posedge clk);
      while (!weights_rdy) @(posedge clk);
      @(negedge clk);
    end
    weights_vld = 1'b0;
  endtask

  task automatic stream_tile(input layer_params_t p, input bit gaps);
    fork
      send_ifmap(ifmap_beats(p), gaps);
      send_weights(weight_beats(p), gaps);
    join
  endtask

  // wait for all expected words and IDLE then check the exact count
  task automatic await_layer_end(input int unsigned first_word, input int n);
    while (i_mon.exp_q.size() != 0) @(negedge clk);
    while (!layer_params_rdy) @(negedge clk);
    repeat (4) @(negedge clk);   // room for stray extra words
    if (i_mon.n_words - first_word != n) begin
      $display("layer gave %0d ofmap words instead of %0d", i_mon.n_words - first_word, n);
      tb_errs++;
    end
  endtask

  // one layer on the tile data now held in ifm and wts
  task automatic run_layer(input layer_params_t p, input bit gaps);
    int          n;
    int unsigned first_word;
    first_word = i_mon.n_words;
    n = conv_ref(p);
    send_params(p);
    stream_tile(p, gaps);
    await_layer_end(first_word, n);
  endtask

  // second params beat waits while the first layer still computes
  task automatic run_back_to_back(input layer_params_t pa, input layer_params_t pb);
    int          na, nb;
    int unsigned first_word;
    first_word = i_mon.n_words;
    fill_data();
    na = conv_ref(pa);
    send_params(pa);
    stream_tile(pa, 1'b0);
    fill_data();
    nb = conv_ref(pb);
    send_params(pb);
    if (i_mon.exp_q.size() != nb) begin
      $display("second layer accepted with %0d words of the first one still owed",
               i_mon.exp_q.size() - nb);
      tb_errs++;
    end
    stream_tile(pb, 1'b0);
    await_layer_end(first_word, na + nb);
  endtask

  task automatic check_reset_outputs();
    if (layer_params_rdy !== 1'b1 || ifmap_rdy !== 1'b0 ||
        weights_rdy !== 1'b0 || ofmap_vld !== 1'b0) begin
      $display("ERR %0t: after reset params_rdy=%b ifmap_rdy=%b weights_rdy=%b ofmap_vld=%b",
               $time, layer_params_rdy, ifmap_rdy, weights_rdy, ofmap_vld);
      tb_errs++;
    end
  endtask

  function automatic int unsigned total_errors();
    return i_mon.n_err + i_mon.n_extra + tb_errs + i_dut.i_chk.n_fail;
  endfunction

  task automatic report_counts();
    $display("summary: %0d words, %0d wrong, %0d unexpected, %0d tb errors, %0d assert fails",
             i_mon.n_words, i_mon.n_err, i_mon.n_extra, tb_errs, i_dut.i_chk.n_fail);
  endtask

  always @(negedge clk) begin
    ofmap_rdy = rdy_random ? (lcg(rng_out) % 10 < 4) : 1'b1;   // about 40 % ready
  end

  initial begin
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the layers did not complete", cycles);
    report_counts();
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    rst_n            = 1'b0;
    ifmap_dat        = '0;
    ifmap_vld        = 1'b0;
    weights_dat      = '0;
    weights_vld      = 1'b0;
    ofmap_rdy        = 1'b0;
    layer_params_dat = '0;
    layer_params_vld = 1'b0;
    rdy_random       = 1'b0;
    rng_dat          = 32'd86740;
    rng_in           = lcg(rng_dat);
    rng_wt           = lcg(rng_dat);
    rng_out          = lcg(rng_dat);
    t_min = make_params(1, 1, 1, 2, 1);
    t_big = make_params(2, 2, 3, 3, 2);
    t_b2b = make_params(1, 2, 2, 2, 1);
    limit = 20 * (2 * layer_cycles(t_min) + 3 * layer_cycles(t_big)
                  + layer_cycles(t_b2b)) + 200;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    check_reset_outputs();
    fill_data();
    run_layer(t_min, 1'b0);
    fill_data();
    run_layer(t_big, 1'b0);
    rdy_random = 1'b1;   // gaps on both inputs and stalls on the ofmap
    run_layer(t_big, 1'b1);   // same tile data as the run before
    run_layer(t_min, 1'b1);   // short pixels fill the FIFO
    rdy_random = 1'b0;
    run_back_to_back(t_b2b, t_big);
    repeat (10) @(negedge clk);
    report_counts();
    if (total_errors() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: conv_tiled.f
+incdir+.
conv_pkg.sv
stream_buffer.sv
loop_sequencer.sv
mac_row.sv
ofmap_serializer.sv
layer_ctrl.sv
conv_tiled.sv
conv_tiled_chk.sv
conv_tiled_mon.sv
tb_conv_tiled.sv

// File: Bender.yml
package:
  name: conv_tiled

sources:
  - include_dirs:
      - .
    files:
      - conv_pkg.sv
      - stream_buffer.sv
      - loop_sequencer.sv
      - mac_row.sv
      - ofmap_serializer.sv
      - layer_ctrl.sv
      - conv_tiled.sv
  - target: test
    include_dirs:
      - .
    files:
      - conv_tiled_chk.sv
      - conv_tiled_mon.sv
      - tb_conv_tiled.sv
